// File: ibuf_consts.svh
`ifndef IBUF_CONSTS_SVH
`define IBUF_CONSTS_SVH

// ----------------------------------------
// frontend geometry
// ----------------------------------------

// lanes per fetch block and per decode group
`define FETCH_WIDTH 4

// queue banking, one bank per lane
`define IBUF_BANK_NUM 4
`define IBUF_BANK_SIZE 4 // words per bank

`define IBUF_SIZE (`IBUF_BANK_NUM * `IBUF_BANK_SIZE)

// ----------------------------------------
// fetch target queue
// ----------------------------------------

`define FSQ_IDX_WIDTH 4

`endif

// File: inst_pkg.sv
`include "ibuf_consts.svh"

package inst_pkg;

    typedef logic [31:0] inst_t;

    typedef logic [`FSQ_IDX_WIDTH-1:0] fsq_idx_t;

    // where an instruction came from
    typedef struct packed {
        fsq_idx_t                          idx;
        logic [$clog2(`FETCH_WIDTH)-1:0]   offset; // lane in original block
    } fsq_info_t;

    // one bank word
    typedef struct packed {
        fsq_info_t fsq;
        inst_t     inst;
    } ibuf_entry_t;

endpackage

// File: lane_pkg.sv
`include "ibuf_consts.svh"

package lane_pkg;

    // one bit per lane
    typedef logic [`FETCH_WIDTH-1:0] lane_mask_t;

    // 0 .. FETCH_WIDTH inclusive
    typedef logic [$clog2(`FETCH_WIDTH):0] lane_cnt_t;

    // lane or bank number
    typedef logic [$clog2(`FETCH_WIDTH)-1:0] lane_idx_t;

endpackage

// File: fetch_align.sv
`timescale 1ns/100ps
`include "ibuf_consts.svh"

module fetch_align
    import inst_pkg::*;
    import lane_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect,
    input  logic        fetch_valid,
    input  inst_t       fetch_inst [`FETCH_WIDTH],
    input  lane_mask_t  fetch_mask,
    input  fsq_idx_t    fetch_fsq_idx,
    output logic        push_valid,
    output lane_cnt_t   push_num,
    output ibuf_entry_t push_entry [`FETCH_WIDTH]
);

    lane_idx_t   lo_lane;  // first valid lane of the block
    lane_cnt_t   mask_cnt;
    ibuf_entry_t aligned [`FETCH_WIDTH];

    always_comb begin
        lo_lane  = '0;
        mask_cnt = '0;
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            if (fetch_mask[i]) lo_lane = lane_idx_t'(i);
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            mask_cnt = mask_cnt + lane_cnt_t'(fetch_mask[i]);
        end
    end

    // shift down by lo_lane, tag with source lane
    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_lane
        lane_idx_t src;
        assign src = lo_lane + lane_idx_t'(i);
        assign aligned[i] = '{fsq: '{idx: fetch_fsq_idx, offset: src}, inst: fetch_inst[src]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_valid <= 1'b0;
            push_num   <= '0;
        end else begin
            push_valid <= fetch_valid & ~redirect; // same-cycle block dropped
            if (fetch_valid) push_num <= mask_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            push_entry <= aligned;
        end
    end

endmodule

// File: ibuf_bank.sv
`timescale 1ns/100ps
`include "ibuf_consts.svh"

module ibuf_bank
    import lane_pkg::*;
#(
    parameter int WIDTH = 38
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             we,
    input  lane_idx_t        waddr,
    input  lane_idx_t        raddr,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] mem [`IBUF_BANK_SIZE];

    assign dout = mem[raddr]; // async read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `IBUF_BANK_SIZE; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= din;
        end
    end

endmodule

// File: inst_buffer.sv
`timescale 1ns/100ps
`include "ibuf_consts.svh"

module inst_buffer
    import inst_pkg::*;
    import lane_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect,
    input  logic        stall,
    input  logic        push_valid,
    input  lane_cnt_t   push_num,
    input  ibuf_entry_t push_entry [`FETCH_WIDTH],
    output lane_cnt_t   pop_num,
    output ibuf_entry_t pop_entry [`FETCH_WIDTH],
    output logic        full
);

    localparam int PTR_W = $clog2(`IBUF_SIZE);

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;  // 0 .. IBUF_SIZE

    lane_idx_t head_bank;
    lane_idx_t tail_bank;
    lane_cnt_t push_cnt;

    lane_idx_t   windex    [`IBUF_BANK_NUM];
    lane_idx_t   rindex    [`IBUF_BANK_NUM];
    logic [`IBUF_BANK_NUM-1:0] bank_we;
    logic [`IBUF_BANK_NUM-1:0] bank_re;
    ibuf_entry_t bank_din  [`IBUF_BANK_NUM];
    ibuf_entry_t bank_dout [`IBUF_BANK_NUM];

    assign head_bank = lane_idx_t'(head);
    assign tail_bank = lane_idx_t'(tail);
    assign push_cnt  = push_valid ? push_num : '0;

    // ----------------------------------------
    // pop and flow control
    // ----------------------------------------

    always_comb begin
        if (stall) begin
            pop_num = '0;
        end else if (count >= `FETCH_WIDTH) begin
            pop_num = lane_cnt_t'(`FETCH_WIDTH);
        end else begin
            pop_num = lane_cnt_t'(count);
        end
    end

    // room for one more full block
    assign full = count > (`IBUF_SIZE - `FETCH_WIDTH);

    // ----------------------------------------
    // banks
    // ----------------------------------------

    for (genvar b = 0; b < `IBUF_BANK_NUM; b++) begin : g_bank
        lane_idx_t wlane;  // push lane landing here
        lane_idx_t rlane;  // output lane reading here

        assign wlane      = lane_idx_t'(b) - tail_bank;
        assign rlane      = lane_idx_t'(b) - head_bank;
        assign bank_we[b] = push_valid && (lane_cnt_t'(wlane) < push_num);
        assign bank_re[b] = lane_cnt_t'(rlane) < pop_num;
        assign bank_din[b] = push_entry[wlane];

        ibuf_bank #(
            .WIDTH ($bits(ibuf_entry_t))
        ) u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (bank_we[b]),
            .waddr (windex[b]),
            .raddr (rindex[b]),
            .din   (bank_din[b]),
            .dout  (bank_dout[b])
        );
    end

    // output lanes rotate from head
    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_rd
        lane_idx_t sel;
        assign sel          = head_bank + lane_idx_t'(i);
        assign pop_entry[i] = bank_dout[sel];
    end

    // ----------------------------------------
    // pointers
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int b = 0; b < `IBUF_BANK_NUM; b++) begin
                windex[b] <= '0;
                rindex[b] <= '0;
            end
        end else if (redirect) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int b = 0; b < `IBUF_BANK_NUM; b++) begin
                windex[b] <= '0;
                rindex[b] <= '0;
            end
        end else begin
            head  <= head + PTR_W'(pop_num);
            tail  <= tail + PTR_W'(push_cnt);
            count <= count + (PTR_W+1)'(push_cnt) - (PTR_W+1)'(pop_num);
            for (int b = 0; b < `IBUF_BANK_NUM; b++) begin
                windex[b] <= windex[b] + lane_idx_t'(bank_we[b]);
                rindex[b] <= rindex[b] + lane_idx_t'(bank_re[b]);
            end
        end
    end

endmodule

// File: decode_latch.sv
`timescale 1ns/100ps
`include "ibuf_consts.svh"

module decode_latch
    import inst_pkg::*;
    import lane_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect,
    input  lane_cnt_t   pop_num,
    input  ibuf_entry_t pop_entry [`FETCH_WIDTH],
    output lane_mask_t  out_en,
    output lane_mask_t  out_branch,
    output inst_t       out_inst [`FETCH_WIDTH],
    output fsq_info_t   out_fsq  [`FETCH_WIDTH]
);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    lane_mask_t en_next;
    lane_mask_t br_next;

    function automatic logic is_branch(input inst_t inst);
        logic [6:0] opc;
        opc = inst[6:0];
        return (opc == OPC_BRANCH) || (opc == OPC_JAL) || (opc == OPC_JALR);
    endfunction

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            en_next[i] = lane_cnt_t'(i) < pop_num;  // contiguous from lane 0
            br_next[i] = en_next[i] && is_branch(pop_entry[i].inst);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_en     <= '0;
            out_branch <= '0;
        end else if (redirect) begin
            out_en     <= '0;
            out_branch <= '0;
        end else begin
            out_en     <= en_next;
            out_branch <= br_next;
        end
    end

    // payload, only enabled lanes load
    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (en_next[i]) begin
                out_inst[i] <= pop_entry[i].inst;
                out_fsq[i]  <= pop_entry[i].fsq;
            end
        end
    end

endmodule

// File: frontend_ibuf.sv
`timescale 1ns/100ps
`include "ibuf_consts.svh"

module frontend_ibuf
    import inst_pkg::*;
    import lane_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       redirect,
    input  logic       stall,
    input  logic       fetch_valid,
    input  inst_t      fetch_inst [`FETCH_WIDTH],
    input  lane_mask_t fetch_mask,
    input  fsq_idx_t   fetch_fsq_idx,
    output logic       full,
    output lane_mask_t out_en,
    output inst_t      out_inst [`FETCH_WIDTH],
    output fsq_info_t  out_fsq  [`FETCH_WIDTH],
    output lane_mask_t out_branch
);

    // align -> buffer
    logic        push_valid;
    lane_cnt_t   push_num;
    ibuf_entry_t push_entry [`FETCH_WIDTH];

    // buffer -> latch
    lane_cnt_t   pop_num;
    ibuf_entry_t pop_entry [`FETCH_WIDTH];

    fetch_align u_fetch_align (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect      (redirect),
        .fetch_valid   (fetch_valid),
        .fetch_inst    (fetch_inst),
        .fetch_mask    (fetch_mask),
        .fetch_fsq_idx (fetch_fsq_idx),
        .push_valid    (push_valid),
        .push_num      (push_num),
        .push_entry    (push_entry)
    );

    inst_buffer u_inst_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .stall      (stall),
        .push_valid (push_valid),
        .push_num   (push_num),
        .push_entry (push_entry),
        .pop_num    (pop_num),
        .pop_entry  (pop_entry),
        .full       (full)
    );

    decode_latch u_decode_latch (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .pop_num    (pop_num),
        .pop_entry  (pop_entry),
        .out_en     (out_en),
        .out_branch (out_branch),
        .out_inst   (out_inst),
        .out_fsq    (out_fsq)
    );

endmodule

// File: frontend_ibuf_props.sv
`timescale 1ns/100ps

module frontend_ibuf_props
    import lane_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       stall,
    input logic       redirect,
    input logic       full,
    input lane_mask_t out_en
);

    lane_mask_t en_plus_one;
    logic       en_contig;

    // a mask of ones from lane 0 turns into a single carry bit
    assign en_plus_one = out_en + lane_mask_t'(1);
    assign en_contig   = (en_plus_one & out_en) == '0;

    property p_stall_holds_group;
        @(posedge clk) disable iff (!rst_n)
        stall |=> (out_en == '0);
    endproperty

    property p_redirect_clears_group;
        @(posedge clk) disable iff (!rst_n)
        redirect |=> (out_en == '0);
    endproperty

    property p_en_contiguous;
        @(posedge clk) disable iff (!rst_n)
        en_contig;
    endproperty

    property p_quiet_after_reset;
        @(posedge clk)
        $rose(rst_n) |-> (out_en == '0) && !full;
    endproperty

    a_stall: assert property (p_stall_holds_group)
        else $error("out_en not zero after a stall cycle");
    a_redirect: assert property (p_redirect_clears_group)
        else $error("out_en not zero after a redirect");
    a_contig: assert property (p_en_contiguous)
        else $error("out_en is not contiguous from lane 0");
    a_reset: assert property (p_quiet_after_reset)
        else $error("out_en or full high right after reset");

endmodule

// File: frontend_ibuf_tb.sv
`timescale 1ns/100ps
`include "ibuf_consts.svh"

module frontend_ibuf_tb
    import inst_pkg::*;
    import lane_pkg::*;
();

    localparam int NUM_BLOCKS     = 300;
    localparam int TIMEOUT_CYCLES = NUM_BLOCKS * `IBUF_SIZE + 500;

    logic        clk;
    logic        rst_n;
    logic        redirect;
    logic        stall;
    logic        fetch_valid;
    inst_t       fetch_inst [`FETCH_WIDTH];
    lane_mask_t  fetch_mask;
    fsq_idx_t    fetch_fsq_idx;
    logic        full;
    lane_mask_t  out_en;
    inst_t       out_inst [`FETCH_WIDTH];
    fsq_info_t   out_fsq  [`FETCH_WIDTH];
    lane_mask_t  out_branch;

    logic [31:0] lcg_state;
    ibuf_entry_t model_q [$];
    int          exp_lanes;      // group size expected after the next edge
    int          pending_lanes;  // strobed, not yet written into the queue
    int          blocks_sent;
    int          cycle_cnt;
    int          mismatch_errs;
    fsq_idx_t    next_fsq;

    frontend_ibuf u_frontend_ibuf (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect      (redirect),
        .stall         (stall),
        .fetch_valid   (fetch_valid),
        .fetch_inst    (fetch_inst),
        .fetch_mask    (fetch_mask),
        .fetch_fsq_idx (fetch_fsq_idx),
        .full          (full),
        .out_en        (out_en),
        .out_inst      (out_inst),
        .out_fsq       (out_fsq),
        .out_branch    (out_branch)
    );

    bind frontend_ibuf frontend_ibuf_props u_props (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .redirect (redirect),
        .full     (full),
        .out_en   (out_en)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // random source and reference rules
    // ----------------------------------------

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand()) % n;
    endfunction

    function automatic inst_t rand_inst();
        inst_t w;
        int    pick;
        w = {next_rand(), next_rand()};
        if (rand_below(4) == 0) begin  // force a control-flow opcode
            pick = rand_below(3);
            case (pick)
                0:       w[6:0] = 7'b1100011;
                1:       w[6:0] = 7'b1101111;
                default: w[6:0] = 7'b1100111;
            endcase
        end
        return w;
    endfunction

    function automatic logic opcode_is_branch(input inst_t w);
        case (w[6:0])
            7'b1100011, 7'b1101111, 7'b1100111: return 1'b1;
            default:                            return 1'b0;
        endcase
    endfunction

    function automatic lane_mask_t low_mask(input int n);
        lane_mask_t m;
        m = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (i < n) m[i] = 1'b1;
        end
        return m;
    endfunction

    function automatic int stall_pct_for(input int blk);
        if (blk >= NUM_BLOCKS / 4 && blk < NUM_BLOCKS / 2) begin
            return 80;  // long stalls, queue fills up
        end
        return 20;
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_fsq(input string name, input fsq_info_t got, input fsq_info_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_mask(input string name, input lane_mask_t got, input lane_mask_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ----------------------------------------
    // per-cycle check and drive
    // ----------------------------------------

    task automatic check_outputs();
        ibuf_entry_t e;
        lane_mask_t  exp_br;
        exp_br = '0;
        check_mask("out_en", out_en, low_mask(exp_lanes));
        for (int i = 0; i < exp_lanes; i++) begin
            e = model_q.pop_front();
            check_inst($sformatf("out_inst[%0d]", i), out_inst[i], e.inst);
            check_fsq($sformatf("out_fsq[%0d]", i), out_fsq[i], e.fsq);
            exp_br[i] = opcode_is_branch(e.inst);
        end
        check_mask("out_branch", out_branch, exp_br);
    endtask

    task automatic drive_inputs(input bit traffic, input int stall_pct);
        int          held;
        int          start;
        int          len;
        logic        do_redirect;
        logic        do_fetch;
        ibuf_entry_t e;

        held = model_q.size() - pending_lanes;  // entries inside the queue now
        check_flag("full", full, (`IBUF_SIZE - held) < `FETCH_WIDTH);

        do_redirect = traffic && (rand_below(64) == 0);
        stall       = traffic && (rand_below(100) < stall_pct);
        redirect    = do_redirect;

        if (do_redirect || stall) begin
            exp_lanes = 0;
        end else if (held >= `FETCH_WIDTH) begin
            exp_lanes = `FETCH_WIDTH;
        end else begin
            exp_lanes = held;
        end
        if (do_redirect) model_q.delete();

        // full lags by one block in flight, keep room for it too
        do_fetch = traffic && !full && (blocks_sent < NUM_BLOCKS)
                   && (model_q.size() <= `IBUF_SIZE - `FETCH_WIDTH)
                   && (rand_below(4) != 0);
        fetch_valid   = do_fetch;
        pending_lanes = 0;
        if (do_fetch) begin
            start         = rand_below(`FETCH_WIDTH);
            len           = 1 + rand_below(`FETCH_WIDTH - start);
            fetch_mask    = lane_mask_t'(((1 << len) - 1) << start);
            fetch_fsq_idx = next_fsq;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                fetch_inst[i] = rand_inst();
            end
            if (!do_redirect) begin  // dropped with the flush otherwise
                for (int j = 0; j < len; j++) begin
                    e.inst       = fetch_inst[lane_idx_t'(start + j)];
                    e.fsq.idx    = next_fsq;
                    e.fsq.offset = lane_idx_t'(start + j);
                    model_q.push_back(e);
                end
                pending_lanes = len;
            end
            next_fsq = fsq_idx_t'(next_fsq + 1);
            blocks_sent++;
        end
    endtask

    task automatic run_cycle(input bit traffic, input int stall_pct);
        @(posedge clk);
        #1;
        check_outputs();
        drive_inputs(traffic, stall_pct);
    endtask

    // ----------------------------------------
    // main flow and watchdog
    // ----------------------------------------

    initial begin : main_flow
        clk           = 1'b0;
        rst_n         = 1'b0;
        redirect      = 1'b0;
        stall         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_mask    = '0;
        fetch_fsq_idx = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            fetch_inst[i] = '0;
        end
        lcg_state     = 32'd10;
        exp_lanes     = 0;
        pending_lanes = 0;
        blocks_sent   = 0;
        mismatch_errs = 0;
        next_fsq      = '0;

        repeat (3) @(posedge clk);
        #1;
        // outputs quiet while held in reset
        check_mask("out_en", out_en, '0);
        check_mask("out_branch", out_branch, '0);
        check_flag("full", full, 1'b0);
        rst_n = 1'b1;

        while (blocks_sent < NUM_BLOCKS) begin
            run_cycle(1'b1, stall_pct_for(blocks_sent));
        end
        while (model_q.size() != 0) begin  // drain, no stall
            run_cycle(1'b0, 0);
        end
        repeat (4) run_cycle(1'b0, 0);

        $display("errors: %0d mismatch", mismatch_errs);
        if (mismatch_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d mismatch", mismatch_errs);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: frontend_ibuf.f
+incdir+.
inst_pkg.sv
lane_pkg.sv
fetch_align.sv
ibuf_bank.sv
inst_buffer.sv
decode_latch.sv
frontend_ibuf.sv
frontend_ibuf_props.sv
frontend_ibuf_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f frontend_ibuf.f \
    --top-module frontend_ibuf_tb \
    -o sim_frontend_ibuf

# keep running past an assertion error so the testbench reaches its verdict
./obj_dir/sim_frontend_ibuf +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
echo "simulation finished without failure"
